//--- flist.f
verilog/bubblePkg.sv
verilog/romPkg.sv
verilog/TimingGenerator.sv
verilog/SPILoader.sv
verilog/BubbleChannel.sv
verilog/BubbleDrive8_emucore.sv
tests/spiFlashModel.sv
tests/tb_emucore_sva.sv
tests/tb_emucore.sv

//--- tests/tb_emucore.sv
`timescale 1ns/1ps

module tb_emucore
    import bubblePkg::*;
    import romPkg::*;
();

// Enough accesses to wrap the position once, plus two boot loops
localparam int numAccesses   = numPages + 3;
localparam int accessCycles  = 1500;
localparam int timeoutCycles = numAccesses * accessCycles;

logic        MCLK, reset, nSYSOK, nBSS, nBSEN, nREPEN, nBOOTEN, nSWAPEN;
logic [2:0]  IMGNUM;
logic        CLKOUT, DOUT0, DOUT1, DOUT2, DOUT3;
logic        nROMCS, ROMMOSI, ROMMISO, ROMCLK, nACC;
logic [31:0] romCmd;

int          errCount = 0;
int          checkCount = 0;
int          cycleCnt = 0;
logic [31:0] rndState;
logic [5:0]  expPos;

BubbleDrive8_emucore dut_i (.*);

spiFlashModel flash_i (
    .nCS     (nROMCS),
    .clk     (ROMCLK),
    .mosi    (ROMMOSI),
    .miso    (ROMMISO),
    .cmdWord (romCmd)
);

initial begin
    MCLK = 1'b0;
    forever #4 MCLK = ~MCLK;
end

always @(posedge MCLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= timeoutCycles) begin
        $display("Timeout: run did not end within %0d MCLK cycles", timeoutCycles);
        $display("Simulation failed");
        $finish;
    end
end

function automatic logic [31:0] lcgNext(input logic [31:0] x);
    return x * 32'd1103515245 + 32'd12345;
endfunction

// Flash content is one LCG step from address plus seed
function automatic logic [7:0] flashByte(input romAddr_t addr);
    logic [31:0] s;
    s = lcgNext(32'(addr) + 32'd61);
    return s[7:0];
endfunction

task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    assert (got === exp) else begin
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errCount++;
    end
endtask

task automatic nextCycle(input int n);
    repeat (n) @(posedge MCLK);
    #1;
endtask

task automatic runAccess(input int num, input logic bootReq);
    romAddr_t         addr;
    logic [5:0]       page;
    logic [63:0]      got [numChannels];
    logic [63:0]      exp;
    logic [7:0]       b;
    int               j;
    int               c;
    int               k;
    int               errStart;
    errStart = errCount;
    rndState = lcgNext(rndState);
    IMGNUM   = rndState[18:16];
    page     = bootReq ? 6'd0 : expPos;
    addr     = romAddr_t'(IMGNUM) * imageBytes + romAddr_t'(page) * pageBytes;
    nBOOTEN  = ~bootReq;
    nBSS     = 1'b0;
    nextCycle(4);
    nBSS    = 1'b1;
    nBOOTEN = 1'b1;
    checkValue("nACC", nACC, 64'd0);
    @(posedge nROMCS);
    checkValue("ROM command", romCmd, {8'h03, addr});
    nextCycle(1);
    nBSEN = 1'b0;
    nextCycle(1);
    nBSEN = 1'b1;
    // Each bit settles one MCLK after the CLKOUT rise
    for (j = 0; j < channelBits; j++) begin
        @(posedge CLKOUT);
        @(posedge MCLK);
        @(negedge MCLK);
        got[0][j] = DOUT0;
        got[1][j] = DOUT1;
        got[2][j] = DOUT2;
        got[3][j] = DOUT3;
        checkValue("nACC", nACC, 64'd0);
    end
    wait (nACC);
    nextCycle(1);
    for (c = 0; c < numChannels; c++) begin
        for (j = 0; j < channelBits; j++) begin
            k      = j * numChannels + c;
            b      = flashByte(addr + romAddr_t'(k / 8));
            exp[j] = b[7 - k % 8];
        end
        checkValue($sformatf("DOUT%0d", c), got[c], exp);
    end
    if (!bootReq) begin
        expPos = expPos + 6'd1;
    end
    $display("access %0d img %0d page %0d boot %0b: %s", num, IMGNUM, page, bootReq,
             (errCount == errStart) ? "ok" : "FAILED");
endtask

initial begin
    int n;
    reset    = 1'b1;
    nSYSOK   = 1'b0;
    nBSS     = 1'b1;
    nBSEN    = 1'b1;
    nREPEN   = 1'b1;
    nBOOTEN  = 1'b1;
    nSWAPEN  = 1'b1;
    IMGNUM   = 3'd0;
    rndState = 32'd61;
    expPos   = 6'd0;
    nextCycle(8);
    checkValue("CLKOUT", CLKOUT, 64'd0);
    checkValue("ROMCLK", ROMCLK, 64'd0);
    checkValue("ROMMOSI", ROMMOSI, 64'd0);
    checkValue("DOUT", {DOUT3, DOUT2, DOUT1, DOUT0}, 64'd0);
    checkValue("nROMCS", nROMCS, 64'd1);
    checkValue("nACC", nACC, 64'd1);
    $display("reset values: %s", (errCount == 0) ? "ok" : "FAILED");
    reset = 1'b0;
    for (n = 0; n < numAccesses; n++) begin
        runAccess(n, n == 5 || n == 30);
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checkCount, errCount,
             dut_i.sva_i.failCount);
    if (errCount == 0 && dut_i.sva_i.failCount == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

//--- tests/tb_emucore_sva.sv
`timescale 1ns/1ps

module tb_emucore_sva (
    input logic MCLK,
    input logic reset,
    input logic CLKOUT,
    input logic nACC,
    input logic nROMCS,
    input logic ROMCLK,
    input logic DOUT0,
    input logic DOUT1,
    input logic DOUT2,
    input logic DOUT3
);

int failCount = 0;

clkHigh: assert property (@(posedge MCLK) disable iff (reset)
    $rose(CLKOUT) |-> CLKOUT [*6] ##1 !CLKOUT)
    else begin
        $error("CLKOUT high phase is not 6 MCLK cycles");
        failCount++;
    end

clkLow: assert property (@(posedge MCLK) disable iff (reset)
    $fell(CLKOUT) |-> !CLKOUT [*6] ##1 CLKOUT)
    else begin
        $error("CLKOUT low phase is not 6 MCLK cycles");
        failCount++;
    end

// No data on the lanes while idle
doutIdle: assert property (@(posedge MCLK) disable iff (reset)
    nACC |-> !(DOUT0 || DOUT1 || DOUT2 || DOUT3))
    else begin
        $error("DOUT active while no access is running");
        failCount++;
    end

romClkIdle: assert property (@(posedge MCLK) disable iff (reset)
    nROMCS |-> !ROMCLK)
    else begin
        $error("ROMCLK toggles while the flash is deselected");
        failCount++;
    end

endmodule

bind BubbleDrive8_emucore tb_emucore_sva sva_i (.*);

//--- tests/spiFlashModel.sv
`timescale 1ns/1ps

module spiFlashModel (
    input  logic        nCS,
    input  logic        clk,
    input  logic        mosi,
    output logic        miso,
    output logic [31:0] cmdWord
);

// Rising clocks since select
int bitCnt = 0;

// One LCG step on address plus seed
function automatic logic [7:0] dataByte(input logic [23:0] addr);
    logic [31:0] s;
    s = (32'(addr) + 32'd61) * 32'd1103515245 + 32'd12345;
    return s[7:0];
endfunction

initial begin
    miso    = 1'b0;
    cmdWord = '0;
end

always @(negedge nCS) begin
    bitCnt = 0;
end

always @(posedge clk) begin
    if (!nCS) begin
        if (bitCnt < 32) begin
            cmdWord = {cmdWord[30:0], mosi};
        end
        bitCnt = bitCnt + 1;
    end
end

// Data shifts out on the falling clock, MSB of each byte first
always @(negedge clk) begin
    logic [7:0] b;
    if (!nCS && bitCnt >= 32) begin
        b = dataByte(cmdWord[23:0] + 24'((bitCnt - 32) / 8));
        miso <= b[7 - (bitCnt - 32) % 8];
    end
end

endmodule

//--- verilog/BubbleDrive8_emucore.sv
`timescale 1ns/1ps

module BubbleDrive8_emucore
    import bubblePkg::*;
(
    // 48 MHz master clock
    input  logic       MCLK,
    input  logic       reset,

    input  logic [2:0] IMGNUM,
    input  logic       nSYSOK,

    // 4 MHz to the host
    output logic       CLKOUT,

    input  logic       nBSS,
    input  logic       nBSEN,
    input  logic       nREPEN,
    input  logic       nBOOTEN,
    input  logic       nSWAPEN,

    output logic       DOUT0,
    output logic       DOUT1,
    output logic       DOUT2,
    output logic       DOUT3,

    // Serial flash
    output logic       nROMCS,
    output logic       ROMMOSI,
    input  logic       ROMMISO,
    output logic       ROMCLK,

    output logic       nACC
);

accCtrl_t               accCtrl;
logic                   loadDone;
bufWrite_t              bufWrite;
logic                   bitStrobe;
logic                   shiftLoad;
logic [numChannels-1:0] chanOut;

TimingGenerator TimingGenerator_0 (
    .MCLK      (MCLK),
    .reset     (reset),
    .nSYSOK    (nSYSOK),
    .nBSS      (nBSS),
    .nBSEN     (nBSEN),
    .nBOOTEN   (nBOOTEN),
    .CLKOUT    (CLKOUT),
    .accCtrl   (accCtrl),
    .loadDone  (loadDone),
    .bitStrobe (bitStrobe),
    .shiftLoad (shiftLoad),
    .nACC      (nACC)
);

SPILoader SPILoader_0 (
    .MCLK     (MCLK),
    .reset    (reset),
    .IMGNUM   (IMGNUM),
    .accCtrl  (accCtrl),
    .loadDone (loadDone),
    .bufWrite (bufWrite),
    .nCS      (nROMCS),
    .MOSI     (ROMMOSI),
    .MISO     (ROMMISO),
    .CLK      (ROMCLK)
);

// Every channel sees the same write, each picks its own bits
for (genvar i = 0; i < numChannels; i++) begin : channelGen
    BubbleChannel #(
        .channelIndex (i)
    ) channel_i (
        .MCLK      (MCLK),
        .reset     (reset),
        .bufWrite  (bufWrite),
        .bitStrobe (bitStrobe),
        .shiftLoad (shiftLoad),
        .dout      (chanOut[i])
    );
end

assign DOUT0 = chanOut[0];
assign DOUT1 = chanOut[1];
assign DOUT2 = chanOut[2];
assign DOUT3 = chanOut[3];

endmodule

//--- verilog/BubbleChannel.sv
`timescale 1ns/1ps

module BubbleChannel
    import bubblePkg::*;
#(
    parameter int channelIndex = 0
)
(
    input  logic      MCLK,
    input  logic      reset,

    input  bufWrite_t bufWrite,

    input  logic      bitStrobe,
    input  logic      shiftLoad,

    output logic      dout
);

logic [channelBits-1:0] pageBuf;
chanAddr_t              readIdx;
logic                   wrapped;

always_ff @(posedge MCLK) begin
    if (bufWrite.en && bufWrite.chan == chanSel_t'(channelIndex)) begin
        pageBuf[bufWrite.addr] <= bufWrite.data;
    end
end

always_ff @(posedge MCLK) begin
    if (reset) begin
        readIdx <= '0;
        wrapped <= 1'b0;
        dout    <= 1'b0;
    end else if (shiftLoad) begin
        readIdx <= '0;
        wrapped <= 1'b0;
        dout    <= 1'b0;
    end else if (bitStrobe) begin
        if (wrapped) begin
            // Strobe after the last bit ends the page
            dout <= 1'b0;
        end else begin
            dout    <= pageBuf[readIdx];
            readIdx <= readIdx + 1'b1;
            if (readIdx == chanAddr_t'(channelBits - 1)) begin
                wrapped <= 1'b1;
            end
        end
    end
end

endmodule

//--- verilog/SPILoader.sv
`timescale 1ns/1ps

module SPILoader
    import bubblePkg::*;
    import romPkg::*;
(
    input  logic       MCLK,
    input  logic       reset,

    input  logic [2:0] IMGNUM,

    input  accCtrl_t   accCtrl,
    output logic       loadDone,

    output bufWrite_t  bufWrite,

    output logic       nCS,
    output logic       MOSI,
    input  logic       MISO,
    output logic       CLK
);

typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_CMD,
    SPI_DATA,
    SPI_END
} spiState_e;

spiState_e             spiState;
accType_e              accPrev;
logic                  phase;
logic [4:0]            cmdCnt;
logic [7:0]            dataCnt;
logic [romCmdBits-1:0] cmdShift;

pagePos_t              page;
romAddr_t              romAddr;
logic                  loadStart;
logic                  sampleBit;

logic                  wrEn;
chanSel_t              wrChan;
chanAddr_t             wrAddr;
logic                  wrData;

// Boot loop always lives on page 0
assign page    = accCtrl.boot ? '0 : accCtrl.absPos;
assign romAddr = romAddr_t'(IMGNUM) * romAddr_t'(imageBytes)
               + romAddr_t'(page) * romAddr_t'(pageBytes);

assign loadStart = (accCtrl.acc == ACC_LOAD) && (accPrev != ACC_LOAD);

// MISO is taken as ROMCLK rises
assign sampleBit = (spiState == SPI_DATA) && !phase;

always_ff @(posedge MCLK) begin
    if (reset) begin
        spiState <= SPI_IDLE;
        accPrev  <= ACC_IDLE;
        phase    <= 1'b0;
        cmdCnt   <= '0;
        dataCnt  <= '0;
        nCS      <= 1'b1;
        MOSI     <= 1'b0;
        CLK      <= 1'b0;
        loadDone <= 1'b0;
        wrEn     <= 1'b0;
    end else begin
        accPrev  <= accCtrl.acc;
        loadDone <= 1'b0;
        wrEn     <= sampleBit;

        case (spiState)
            SPI_IDLE: begin
                if (loadStart) begin
                    nCS      <= 1'b0;
                    MOSI     <= romReadCmd[7];
                    phase    <= 1'b0;
                    cmdCnt   <= '0;
                    spiState <= SPI_CMD;
                end
            end

            SPI_CMD: begin
                phase <= ~phase;
                CLK   <= ~phase;
                // MOSI moves with the falling ROMCLK
                if (phase) begin
                    if (cmdCnt == 5'(romCmdBits - 1)) begin
                        MOSI     <= 1'b0;
                        dataCnt  <= '0;
                        spiState <= SPI_DATA;
                    end else begin
                        MOSI   <= cmdShift[romCmdBits-2];
                        cmdCnt <= cmdCnt + 5'd1;
                    end
                end
            end

            SPI_DATA: begin
                phase <= ~phase;
                CLK   <= ~phase;
                if (phase) begin
                    dataCnt <= dataCnt + 8'd1;
                    if (dataCnt == 8'(pageBits - 1)) begin
                        spiState <= SPI_END;
                    end
                end
            end

            SPI_END: begin
                // Two idle cycles before deselect
                phase <= ~phase;
                if (phase) begin
                    nCS      <= 1'b1;
                    loadDone <= 1'b1;
                    spiState <= SPI_IDLE;
                end
            end

            default: spiState <= SPI_IDLE;
        endcase
    end
end

always_ff @(posedge MCLK) begin
    if (spiState == SPI_IDLE && loadStart) begin
        cmdShift <= {romReadCmd, romAddr};
    end else if (spiState == SPI_CMD && phase) begin
        cmdShift <= cmdShift << 1;
    end

    // Page bit k lands in channel k mod 4 at address k/4
    if (sampleBit) begin
        wrChan <= dataCnt[1:0];
        wrAddr <= dataCnt[7:2];
        wrData <= MISO;
    end
end

assign bufWrite = '{en: wrEn, chan: wrChan, addr: wrAddr, data: wrData};

endmodule

//--- verilog/TimingGenerator.sv
`timescale 1ns/1ps

module TimingGenerator
    import bubblePkg::*;
(
    input  logic     MCLK,
    input  logic     reset,

    input  logic     nSYSOK,
    input  logic     nBSS,
    input  logic     nBSEN,
    input  logic     nBOOTEN,

    output logic     CLKOUT,

    output accCtrl_t accCtrl,
    input  logic     loadDone,

    output logic     bitStrobe,
    output logic     shiftLoad,

    output logic     nACC
);

logic [3:0] divCnt;
logic       clkRise;

logic [2:0] bssSync;
logic       bssFall;

accType_e   state;
pagePos_t   absPos;
logic       boot;
logic [6:0] outCnt;

// CLKOUT goes high on the next edge
assign clkRise = (divCnt == 4'(clkDiv - 1));

// Two sync stages, third one for the edge
assign bssFall = bssSync[2] & ~bssSync[1];

always_ff @(posedge MCLK) begin
    if (reset) begin
        // Start mid-period so the first low phase is a full half period
        divCnt <= 4'(clkDiv / 2);
        CLKOUT <= 1'b0;
    end else begin
        if (clkRise) begin
            divCnt <= '0;
            CLKOUT <= 1'b1;
        end else begin
            divCnt <= divCnt + 4'd1;
            if (divCnt == 4'(clkDiv / 2 - 1)) begin
                CLKOUT <= 1'b0;
            end
        end
    end
end

always_ff @(posedge MCLK) begin
    if (reset) begin
        bssSync <= '1;
    end else begin
        bssSync <= {bssSync[1:0], nBSS};
    end
end

always_ff @(posedge MCLK) begin
    if (reset) begin
        state     <= ACC_IDLE;
        absPos    <= '0;
        boot      <= 1'b0;
        outCnt    <= '0;
        bitStrobe <= 1'b0;
        shiftLoad <= 1'b0;
    end else begin
        bitStrobe <= 1'b0;
        shiftLoad <= 1'b0;

        case (state)
            ACC_IDLE: begin
                if (bssFall && !nSYSOK) begin
                    state <= ACC_LOAD;
                    boot  <= ~nBOOTEN;
                end
            end

            ACC_LOAD: begin
                if (loadDone) begin
                    state <= ACC_WAIT;
                end
            end

            ACC_WAIT: begin
                if (!nBSEN) begin
                    state     <= ACC_OUT;
                    shiftLoad <= 1'b1;
                    outCnt    <= '0;
                end
            end

            ACC_OUT: begin
                if (clkRise) begin
                    bitStrobe <= 1'b1;
                    outCnt    <= outCnt + 7'd1;
                end
                // Strobe after bit 63 closes the page, channels drop DOUT here too
                if (bitStrobe && outCnt == 7'(channelBits + 1)) begin
                    state <= ACC_IDLE;
                    if (!boot) begin
                        absPos <= absPos + 1'b1;
                    end
                end
            end

            default: state <= ACC_IDLE;
        endcase
    end
end

assign accCtrl = '{acc: state, absPos: absPos, boot: boot};

// Access LED
assign nACC = (state == ACC_IDLE);

endmodule

//--- verilog/romPkg.sv
package romPkg;

// Standard serial flash read
localparam logic [7:0] romReadCmd = 8'h03;

typedef logic [23:0] romAddr_t;

// Image and page layout in the flash
localparam int imageBytes = 2048;
localparam int pageBytes  = 32;

// Command byte followed by a 24-bit address
localparam int romCmdBits = 8 + $bits(romAddr_t);

endpackage

//--- verilog/bubblePkg.sv
package bubblePkg;

// Drive geometry
localparam int numChannels = 4;
localparam int pageBits    = 256;
localparam int channelBits = pageBits / numChannels;
localparam int numPages    = 64;

// MCLK cycles per CLKOUT period, 48 MHz down to 4 MHz
localparam int clkDiv = 12;

typedef logic [$clog2(numPages)-1:0]    pagePos_t;
typedef logic [$clog2(channelBits)-1:0] chanAddr_t;
typedef logic [$clog2(numChannels)-1:0] chanSel_t;

// Access cycle of one page
typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_LOAD,
    ACC_WAIT,
    ACC_OUT
} accType_e;

// One bit into one of the page buffers
typedef struct packed {
    logic      en;
    chanSel_t  chan;
    chanAddr_t addr;
    logic      data;
} bufWrite_t;

// Access request to the loader
typedef struct packed {
    accType_e acc;
    pagePos_t absPos;
    logic     boot;
} accCtrl_t;

endpackage
